/* build.f */
+incdir+hw
hw/cnn_addr_pkg.sv
hw/layer_sequencer.sv
hw/conv_window_addr.sv
hw/conv_store_addr.sv
hw/pool_window_addr.sv
hw/cnn_addr_top.sv
tb/cnn_addr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the conv1/pool1 address testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert -f build.f --top-module cnn_addr_tb -o cnn_addr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cnn_addr_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Verification passed$" "$log_file"; then
    exit 0
else
    echo "pass message not found in $log_file"
    exit 1
fi

/* tb/cnn_addr_tb.sv */
// ================================================
// Testbench for the conv1/pool1 address subsystem.
// Concurrent assertions do all checking against
// reference counters kept here. Run 1 has no hold,
// run 2 uses a random hold and must give the same
// address sequences. Needs assertions enabled.
// ================================================
`timescale 1ns/1ns
`default_nettype none
`include "cnn_addr_cfg.svh"

module cnn_addr_tb
    import cnn_addr_pkg::*;
();

    logic         clk = 1'b0;
    logic         reset;
    logic         i_start;
    logic         i_hold;
    logic         o_busy;
    logic         o_done;
    logic         o_cr_valid;
    img_addr_t    o_cr_addr0;
    img_addr_t    o_cr_addr1;
    img_addr_t    o_cr_addr2;
    img_addr_t    o_cr_addr3;
    kernel_addr_t o_k_addr;
    logic         o_cw_valid;
    conv_addr_t   o_cw_addr0;
    conv_addr_t   o_cw_addr1;
    conv_addr_t   o_cw_addr2;
    conv_addr_t   o_cw_addr3;
    logic         o_pr_valid;
    conv_addr_t   o_pr_addr0;
    conv_addr_t   o_pr_addr1;
    conv_addr_t   o_pr_addr2;
    conv_addr_t   o_pr_addr3;
    logic         o_pw_valid;
    pool_addr_t   o_pw_addr;

    img_addr_t    cr_addr [4];
    conv_addr_t   cw_addr [4];
    conv_addr_t   pr_addr [4];

    // reference state
    int           rd_cnt;
    int           cw_cnt;
    int           pr_cnt;
    int           pw_cnt;
    int           runs_done;
    logic [31:0]  read_sig;
    logic [31:0]  write_sig;
    logic [31:0]  first_read_sig;
    logic [31:0]  first_write_sig;
    int           value_errors = 0;
    int           protocol_errors = 0;
    logic         started = 1'b0;
    logic         hold_on = 1'b0;
    logic [31:0]  lcg_state = 32'd67499;

    always #2 clk = ~clk;

    cnn_addr_top i_cnn_addr_top (
        .clk        (clk),
        .reset      (reset),
        .i_start    (i_start),
        .i_hold     (i_hold),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_cr_valid (o_cr_valid),
        .o_cr_addr0 (o_cr_addr0),
        .o_cr_addr1 (o_cr_addr1),
        .o_cr_addr2 (o_cr_addr2),
        .o_cr_addr3 (o_cr_addr3),
        .o_k_addr   (o_k_addr),
        .o_cw_valid (o_cw_valid),
        .o_cw_addr0 (o_cw_addr0),
        .o_cw_addr1 (o_cw_addr1),
        .o_cw_addr2 (o_cw_addr2),
        .o_cw_addr3 (o_cw_addr3),
        .o_pr_valid (o_pr_valid),
        .o_pr_addr0 (o_pr_addr0),
        .o_pr_addr1 (o_pr_addr1),
        .o_pr_addr2 (o_pr_addr2),
        .o_pr_addr3 (o_pr_addr3),
        .o_pw_valid (o_pw_valid),
        .o_pw_addr  (o_pw_addr)
    );

    assign cr_addr = '{o_cr_addr0, o_cr_addr1, o_cr_addr2, o_cr_addr3};
    assign cw_addr = '{o_cw_addr0, o_cw_addr1, o_cw_addr2, o_cw_addr3};
    assign pr_addr = '{o_pr_addr0, o_pr_addr1, o_pr_addr2, o_pr_addr3};

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // image address of read number idx in a lane with 25 taps per window
    function automatic int conv_read_addr(input int lane, input int idx);
        int n;
        int tap;
        n   = idx / (`CNN_KSIZE * `CNN_KSIZE);
        tap = idx % (`CNN_KSIZE * `CNN_KSIZE);
        return (`CNN_LANE_ROWS * lane + n / `CNN_CONV_W + tap / `CNN_KSIZE) * `CNN_IMG_W
             + n % `CNN_CONV_W + tap % `CNN_KSIZE;
    endfunction

    // j picks top-left, top-right, bottom-left, bottom-right
    function automatic int pool_read_addr(input int j, input int m);
        return 2 * `CNN_CONV_W * (m / `CNN_POOL_W) + 2 * (m % `CNN_POOL_W)
             + (j / 2) * `CNN_CONV_W + j % 2;
    endfunction

    function automatic logic [31:0] sig_step(input logic [31:0] sig, input logic [31:0] v);
        return {sig[30:0], sig[31]} ^ v;
    endfunction

    task automatic report_value(input string name, input int got, input int expected);
        value_errors++;
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("[ERROR] %s", what);
    endtask

    always @(negedge clk) begin
        lcg_state = lcg_next(lcg_state);
        i_hold = hold_on && (lcg_state[17:16] == 2'b00);
    end

    // reference counters and per-run signatures
    // read and write streams never overlap in time
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_cnt          <= 0;
            cw_cnt          <= 0;
            pr_cnt          <= 0;
            pw_cnt          <= 0;
            runs_done       <= 0;
            read_sig        <= '0;
            write_sig       <= '0;
            first_read_sig  <= '0;
            first_write_sig <= '0;
        end else if (o_done) begin
            rd_cnt    <= 0;
            cw_cnt    <= 0;
            pr_cnt    <= 0;
            pw_cnt    <= 0;
            read_sig  <= '0;
            write_sig <= '0;
            runs_done <= runs_done + 1;
            if (runs_done == 0) begin
                first_read_sig  <= read_sig;
                first_write_sig <= write_sig;
            end
        end else begin
            if (o_cr_valid) begin
                rd_cnt   <= rd_cnt + 1;
                read_sig <= sig_step(read_sig, {o_cr_addr0, o_cr_addr3, 7'd0, o_k_addr});
            end
            if (o_pr_valid) begin
                pr_cnt   <= pr_cnt + 1;
                read_sig <= sig_step(read_sig, {o_pr_addr0, o_pr_addr3, 12'hfff});
            end
            if (o_cw_valid) begin
                cw_cnt    <= cw_cnt + 1;
                write_sig <= sig_step(write_sig, {o_cw_addr0, o_cw_addr3, 12'd0});
            end
            if (o_pw_valid) begin
                pw_cnt    <= pw_cnt + 1;
                write_sig <= sig_step(write_sig, {24'd0, o_pw_addr});
            end
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (reset)
        !started |-> !(o_busy || o_done || o_cr_valid || o_cw_valid || o_pr_valid || o_pw_valid))
        else report_protocol("an output was active before the first start");
    a_busy_on_start: assert property (@(posedge clk) disable iff (reset)
        (i_start && !o_busy) |=> o_busy)
        else report_protocol("o_busy did not rise after an accepted start");
    a_busy_only_on_start: assert property (@(posedge clk) disable iff (reset)
        $rose(o_busy) |-> $past(i_start && !o_busy))
        else report_protocol("o_busy rose without a start in idle");
    a_no_read_in_hold: assert property (@(posedge clk) disable iff (reset)
        i_hold |-> !(o_cr_valid || o_pr_valid))
        else report_protocol("a read valid was raised during a hold cycle");

    for (genvar k = 0; k < `CNN_LANES; k++) begin : g_lane
        a_cr_addr: assert property (@(posedge clk) disable iff (reset)
            o_cr_valid |-> int'(cr_addr[k]) == conv_read_addr(k, rd_cnt))
            else report_value($sformatf("o_cr_addr%0d", k), int'($sampled(cr_addr[k])),
                              conv_read_addr(k, $sampled(rd_cnt)));
        a_cw_addr: assert property (@(posedge clk) disable iff (reset)
            o_cw_valid |-> int'(cw_addr[k]) == `CNN_LANE_WINDOWS * k + cw_cnt)
            else report_value($sformatf("o_cw_addr%0d", k), int'($sampled(cw_addr[k])),
                              `CNN_LANE_WINDOWS * k + $sampled(cw_cnt));
        a_pr_addr: assert property (@(posedge clk) disable iff (reset)
            o_pr_valid |-> int'(pr_addr[k]) == pool_read_addr(k, pr_cnt))
            else report_value($sformatf("o_pr_addr%0d", k), int'($sampled(pr_addr[k])),
                              pool_read_addr(k, $sampled(pr_cnt)));
        if (k > 0) begin : g_gap
            a_lane_gap: assert property (@(posedge clk) disable iff (reset)
                o_cr_valid |-> int'(cr_addr[k]) - int'(cr_addr[k-1]) == 168)
                else report_value($sformatf("o_cr_addr%0d - o_cr_addr%0d", k, k - 1),
                                  int'($sampled(cr_addr[k])) - int'($sampled(cr_addr[k-1])),
                                  168);
        end
    end

    a_k_addr: assert property (@(posedge clk) disable iff (reset)
        o_cr_valid |-> int'(o_k_addr) == rd_cnt % 25)
        else report_value("o_k_addr", int'($sampled(o_k_addr)), $sampled(rd_cnt) % 25);
    a_read_limit: assert property (@(posedge clk) disable iff (reset)
        o_cr_valid |-> rd_cnt < 3600)
        else report_protocol("more than 3600 convolution reads in one run");
    a_cw_after_tap: assert property (@(posedge clk) disable iff (reset)
        o_cw_valid |-> $past(o_cr_valid && o_k_addr == 5'd24))
        else report_protocol("o_cw_valid without a last-tap read one cycle before");
    a_tap_then_cw: assert property (@(posedge clk) disable iff (reset)
        (o_cr_valid && o_k_addr == 5'd24) |=> o_cw_valid)
        else report_protocol("no o_cw_valid one cycle after a last-tap read");
    a_pool_after_conv: assert property (@(posedge clk) disable iff (reset)
        o_pr_valid |-> cw_cnt == 144)
        else report_protocol("pooling read before all 144 convolution writes");
    a_pw_after_pr: assert property (@(posedge clk) disable iff (reset)
        o_pw_valid |-> $past(o_pr_valid))
        else report_protocol("o_pw_valid without a pooling read one cycle before");
    a_pr_then_pw: assert property (@(posedge clk) disable iff (reset)
        o_pr_valid |=> o_pw_valid)
        else report_protocol("no o_pw_valid one cycle after a pooling read");
    a_pw_addr: assert property (@(posedge clk) disable iff (reset)
        o_pw_valid |-> int'(o_pw_addr) == pw_cnt)
        else report_value("o_pw_addr", int'($sampled(o_pw_addr)), $sampled(pw_cnt));
    a_done_timing: assert property (@(posedge clk) disable iff (reset)
        o_done |-> !o_busy && $past(o_busy) && $past(o_pw_valid))
        else report_protocol("o_done not one cycle after the last pooling write with busy low");
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        o_done |=> !o_done)
        else report_protocol("o_done stayed high for more than one cycle");
    a_done_counts: assert property (@(posedge clk) disable iff (reset)
        o_done |-> rd_cnt == 3600 && cw_cnt == 144 && pr_cnt == 144 && pw_cnt == 144)
        else report_protocol($sformatf("wrong counts at o_done: %0d %0d %0d %0d",
                             $sampled(rd_cnt), $sampled(cw_cnt),
                             $sampled(pr_cnt), $sampled(pw_cnt)));
    a_same_sequence: assert property (@(posedge clk) disable iff (reset)
        (o_done && runs_done > 0) |-> read_sig == first_read_sig
                                      && write_sig == first_write_sig)
        else report_protocol("address sequence of this run differs from the first run");

    task automatic pulse_start();
        started = 1'b1;
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!o_done && cycles <= limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_done) begin
            report_protocol($sformatf("timeout, o_done did not pulse within %0d cycles",
                                      limit));
        end
    endtask

    initial begin
        reset   = 1'b1;
        i_start = 1'b0;
        i_hold  = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (10) @(negedge clk);
        // first run without holds
        // a second start while busy must be ignored
        pulse_start();
        repeat (1000) @(negedge clk);
        pulse_start();
        wait_for_done(6000);
        repeat (5) @(negedge clk);
        // second run with random holds
        hold_on = 1'b1;
        pulse_start();
        repeat (2000) @(negedge clk);
        pulse_start();
        wait_for_done(20000);
        hold_on = 1'b0;
        repeat (5) @(negedge clk);
        $display("errors: value %0d, protocol %0d, runs done %0d",
                 value_errors, protocol_errors, runs_done);
        if (value_errors == 0 && protocol_errors == 0 && runs_done == 2) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cnn_addr_top.sv */
// ================================================
// conv1 and pool1 address generation subsystem.
// Only addresses and valids leave this block, the
// memories sit outside. i_hold stalls all reads
// while the memory side is not ready.
// ================================================
`timescale 1ns/1ns
`default_nettype none

module cnn_addr_top
    import cnn_addr_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         i_start,
    input  logic         i_hold,
    output logic         o_busy,
    output logic         o_done,
    output logic         o_cr_valid,
    output img_addr_t    o_cr_addr0,
    output img_addr_t    o_cr_addr1,
    output img_addr_t    o_cr_addr2,
    output img_addr_t    o_cr_addr3,
    output kernel_addr_t o_k_addr,
    output logic         o_cw_valid,
    output conv_addr_t   o_cw_addr0,
    output conv_addr_t   o_cw_addr1,
    output conv_addr_t   o_cw_addr2,
    output conv_addr_t   o_cw_addr3,
    output logic         o_pr_valid,
    output conv_addr_t   o_pr_addr0,
    output conv_addr_t   o_pr_addr1,
    output conv_addr_t   o_pr_addr2,
    output conv_addr_t   o_pr_addr3,
    output logic         o_pw_valid,
    output pool_addr_t   o_pw_addr
);

    logic conv_run;
    logic pool_run;
    logic conv_finished;
    logic pool_finished;
    logic last_tap;

    layer_sequencer i_layer_sequencer (
        .clk             (clk),
        .reset           (reset),
        .i_start         (i_start),
        .i_conv_finished (conv_finished),
        .i_pool_finished (pool_finished),
        .o_conv_run      (conv_run),
        .o_pool_run      (pool_run),
        .o_busy          (o_busy),
        .o_done          (o_done)
    );

    conv_window_addr i_conv_window_addr (
        .clk        (clk),
        .reset      (reset),
        .i_run      (conv_run),
        .i_hold     (i_hold),
        .o_valid    (o_cr_valid),
        .o_addr0    (o_cr_addr0),
        .o_addr1    (o_cr_addr1),
        .o_addr2    (o_cr_addr2),
        .o_addr3    (o_cr_addr3),
        .o_k_addr   (o_k_addr),
        .o_last_tap (last_tap)
    );

    conv_store_addr i_conv_store_addr (
        .clk        (clk),
        .reset      (reset),
        .i_run      (conv_run),
        .i_last_tap (last_tap),
        .o_valid    (o_cw_valid),
        .o_addr0    (o_cw_addr0),
        .o_addr1    (o_cw_addr1),
        .o_addr2    (o_cw_addr2),
        .o_addr3    (o_cw_addr3),
        .o_finished (conv_finished)
    );

    pool_window_addr i_pool_window_addr (
        .clk        (clk),
        .reset      (reset),
        .i_run      (pool_run),
        .i_hold     (i_hold),
        .o_rd_valid (o_pr_valid),
        .o_rd_addr0 (o_pr_addr0),
        .o_rd_addr1 (o_pr_addr1),
        .o_rd_addr2 (o_pr_addr2),
        .o_rd_addr3 (o_pr_addr3),
        .o_wr_valid (o_pw_valid),
        .o_wr_addr  (o_pw_addr),
        .o_finished (pool_finished)
    );

endmodule

`default_nettype wire

/* hw/pool_window_addr.sv */
// ================================================
// 2x2 pooling over the 24x24 convolution map.
// Four read addresses per window, one per cycle
// while i_run is high and i_hold is low. The
// write address follows its read by one cycle
// and is issued even if a hold starts meanwhile.
// ================================================
`timescale 1ns/1ns
`default_nettype none
`include "cnn_addr_cfg.svh"

module pool_window_addr
    import cnn_addr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_run,
    input  logic       i_hold,
    output logic       o_rd_valid,
    output conv_addr_t o_rd_addr0,
    output conv_addr_t o_rd_addr1,
    output conv_addr_t o_rd_addr2,
    output conv_addr_t o_rd_addr3,
    output logic       o_wr_valid,
    output pool_addr_t o_wr_addr,
    output logic       o_finished
);

    localparam logic [3:0] col_last = 4'(`CNN_POOL_W - 1);
    localparam pool_addr_t win_last = pool_addr_t'(`CNN_POOL_W * `CNN_POOL_W - 1);
    // two pixels right, or skip the odd row at the end of a line
    localparam int step_col = 2;
    localparam int step_line = `CNN_CONV_W + 2;

    conv_addr_t rd_base;
    logic [3:0] col;
    pool_addr_t win;
    logic       rd_done;

    assign o_rd_valid = i_run && !i_hold && !rd_done;
    assign o_rd_addr0 = rd_base;
    assign o_rd_addr1 = rd_base + conv_addr_t'(1);
    assign o_rd_addr2 = rd_base + conv_addr_t'(`CNN_CONV_W);
    assign o_rd_addr3 = rd_base + conv_addr_t'(`CNN_CONV_W + 1);

    assign o_finished = o_wr_valid && (o_wr_addr == win_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset || !i_run) begin
            rd_base <= '0;
            col     <= '0;
            win     <= '0;
            rd_done <= 1'b0;
        end else if (o_rd_valid) begin
            win <= win + pool_addr_t'(1);
            if (col == col_last) begin
                col     <= '0;
                rd_base <= rd_base + conv_addr_t'(step_line);
            end else begin
                col     <= col + 4'd1;
                rd_base <= rd_base + conv_addr_t'(step_col);
            end
            if (win == win_last) begin
                rd_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_wr_valid <= 1'b0;
        end else begin
            o_wr_valid <= o_rd_valid;
        end
    end

    // write address is the window index of the read one cycle earlier
    always_ff @(posedge clk) begin
        if (o_rd_valid) begin
            o_wr_addr <= win;
        end
    end

endmodule

`default_nettype wire

/* hw/conv_store_addr.sv */
// ================================================
// Convolution output write addresses, one per
// finished window in each of the four lanes.
// The write comes one cycle after the last-tap
// strobe and is not affected by a read hold.
// ================================================
`timescale 1ns/1ns
`default_nettype none
`include "cnn_addr_cfg.svh"

module conv_store_addr
    import cnn_addr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_run,
    input  logic       i_last_tap,
    output logic       o_valid,
    output conv_addr_t o_addr0,
    output conv_addr_t o_addr1,
    output conv_addr_t o_addr2,
    output conv_addr_t o_addr3,
    output logic       o_finished
);

    localparam conv_addr_t win_last = conv_addr_t'(`CNN_LANE_WINDOWS - 1);

    conv_addr_t lane_addr [`CNN_LANES];

    assign o_addr0 = lane_addr[0];
    assign o_addr1 = lane_addr[1];
    assign o_addr2 = lane_addr[2];
    assign o_addr3 = lane_addr[3];

    // lane 0 counts from zero, so it also tells the window number
    assign o_finished = o_valid && (lane_addr[0] == win_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_last_tap;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset || !i_run) begin
            for (int k = 0; k < `CNN_LANES; k++) begin
                lane_addr[k] <= conv_addr_t'(k * `CNN_LANE_WINDOWS);
            end
        end else if (o_valid) begin
            for (int k = 0; k < `CNN_LANES; k++) begin
                lane_addr[k] <= lane_addr[k] + conv_addr_t'(1);
            end
        end
    end

    a_write_after_tap: assert property (@(posedge clk) disable iff (reset)
        o_valid |-> $past(i_last_tap && i_run));

endmodule

`default_nettype wire

/* hw/conv_window_addr.sv */
// ================================================
// Sliding 5x5 window over the input image, four
// lanes of six output rows each.
// Read outputs are combinational on the counters.
// One tap is issued per cycle while i_run is high
// and i_hold is low. After the last tap of the
// last window no more reads are issued until
// i_run drops.
// ================================================
`timescale 1ns/1ns
`default_nettype none
`include "cnn_addr_cfg.svh"

module conv_window_addr
    import cnn_addr_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         i_run,
    input  logic         i_hold,
    output logic         o_valid,
    output img_addr_t    o_addr0,
    output img_addr_t    o_addr1,
    output img_addr_t    o_addr2,
    output img_addr_t    o_addr3,
    output kernel_addr_t o_k_addr,
    output logic         o_last_tap
);

    // offset between lanes, six image rows
    localparam int lane_step = `CNN_LANE_ROWS * `CNN_IMG_W;
    // end of kernel row, one row down and back to the window's first column
    localparam int step_row = `CNN_IMG_W - `CNN_KSIZE + 1;
    // back to the top row of the window, one pixel to the right
    localparam int step_win = (`CNN_KSIZE - 1) * `CNN_IMG_W + `CNN_KSIZE - 2;
    // back to the first column, one output row down
    localparam int step_line = (`CNN_KSIZE - 2) * `CNN_IMG_W + `CNN_CONV_W + `CNN_KSIZE - 2;
    localparam int img_max =
        (`CNN_LANES * `CNN_LANE_ROWS + `CNN_KSIZE - 1) * `CNN_IMG_W - 1;
    localparam logic [2:0] tap_last = 3'(`CNN_KSIZE - 1);
    localparam logic [4:0] col_last = 5'(`CNN_CONV_W - 1);
    localparam logic [2:0] row_last = 3'(`CNN_LANE_ROWS - 1);

    img_addr_t  lane_addr [`CNN_LANES];
    logic [2:0] tap_col;
    logic [2:0] tap_row;
    logic [4:0] win_col;
    logic [2:0] win_row;
    logic       lane_done;
    logic       win_end;

    assign win_end    = (tap_col == tap_last) && (tap_row == tap_last);
    assign o_valid    = i_run && !i_hold && !lane_done;
    assign o_last_tap = o_valid && win_end;
    assign o_k_addr   = kernel_addr_t'(tap_row) * kernel_addr_t'(`CNN_KSIZE)
                      + kernel_addr_t'(tap_col);

    assign o_addr0 = lane_addr[0];
    assign o_addr1 = lane_addr[1];
    assign o_addr2 = lane_addr[2];
    assign o_addr3 = lane_addr[3];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `CNN_LANES; k++) begin
                lane_addr[k] <= img_addr_t'(k * lane_step);
            end
            tap_col   <= '0;
            tap_row   <= '0;
            win_col   <= '0;
            win_row   <= '0;
            lane_done <= 1'b0;
        end else if (!i_run) begin
            // idle between runs, park at the first tap of each lane
            for (int k = 0; k < `CNN_LANES; k++) begin
                lane_addr[k] <= img_addr_t'(k * lane_step);
            end
            tap_col   <= '0;
            tap_row   <= '0;
            win_col   <= '0;
            win_row   <= '0;
            lane_done <= 1'b0;
        end else if (o_valid) begin
            if (win_end) begin
                tap_col <= '0;
                tap_row <= '0;
                if (win_col == col_last) begin
                    win_col <= '0;
                    win_row <= win_row + 3'd1;
                    for (int k = 0; k < `CNN_LANES; k++) begin
                        lane_addr[k] <= lane_addr[k] - img_addr_t'(step_line);
                    end
                    if (win_row == row_last) begin
                        lane_done <= 1'b1;
                    end
                end else begin
                    win_col <= win_col + 5'd1;
                    for (int k = 0; k < `CNN_LANES; k++) begin
                        lane_addr[k] <= lane_addr[k] - img_addr_t'(step_win);
                    end
                end
            end else if (tap_col == tap_last) begin
                tap_col <= '0;
                tap_row <= tap_row + 3'd1;
                for (int k = 0; k < `CNN_LANES; k++) begin
                    lane_addr[k] <= lane_addr[k] + img_addr_t'(step_row);
                end
            end else begin
                tap_col <= tap_col + 3'd1;
                for (int k = 0; k < `CNN_LANES; k++) begin
                    lane_addr[k] <= lane_addr[k] + img_addr_t'(1);
                end
            end
        end
    end

    // the last lane carries the highest address, so bounding it bounds all four
    a_lane_in_image: assert property (@(posedge clk) disable iff (reset)
        o_valid |-> (int'(lane_addr[`CNN_LANES-1]) <= img_max));

endmodule

`default_nettype wire

/* hw/layer_sequencer.sv */
// ================================================
// Runs the conv1 phase and then the pool1 phase
// after a start pulse.
// i_start is only sampled while idle. o_done
// pulses for one cycle as the FSM returns to
// idle, the same cycle o_busy falls.
// ================================================
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer
    import cnn_addr_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic i_start,
    input  logic i_conv_finished,
    input  logic i_pool_finished,
    output logic o_conv_run,
    output logic o_pool_run,
    output logic o_busy,
    output logic o_done
);

    layer_phase_t phase;
    logic         done_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase  <= phase_idle;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (phase)
                phase_idle: begin
                    if (i_start) begin
                        phase <= phase_conv;
                    end
                end
                phase_conv: begin
                    // pooling reads start the cycle after the last conv write
                    if (i_conv_finished) begin
                        phase <= phase_pool;
                    end
                end
                phase_pool: begin
                    if (i_pool_finished) begin
                        phase  <= phase_idle;
                        done_r <= 1'b1;
                    end
                end
                default: begin
                    phase <= phase_idle;
                end
            endcase
        end
    end

    assign o_conv_run = (phase == phase_conv);
    assign o_pool_run = (phase == phase_pool);
    assign o_busy     = (phase != phase_idle);
    assign o_done     = done_r;

    a_one_phase: assert property (@(posedge clk) disable iff (reset)
        !(o_conv_run && o_pool_run));

endmodule

`default_nettype wire

/* hw/cnn_addr_pkg.sv */
// ================================================
// Address and phase types for the conv1/pool1
// address generators.
// Widths are sized for a 28x28 image, a 5x5 kernel
// and 2x2 pooling only. Other layer sizes need new
// widths here.
// ================================================
`default_nettype none

package cnn_addr_pkg;

    // input image, 784 pixels
    typedef logic [9:0] img_addr_t;

    // conv1 output map, 576 results
    typedef logic [9:0] conv_addr_t;

    // pool1 output map, 144 results
    typedef logic [7:0] pool_addr_t;

    // one 5x5 kernel, 25 weights
    typedef logic [4:0] kernel_addr_t;

    typedef enum logic [1:0] {
        phase_idle = 2'd0,
        phase_conv = 2'd1,
        phase_pool = 2'd2
    } layer_phase_t;

endpackage

`default_nettype wire

/* hw/cnn_addr_cfg.svh */
// ================================================
// Layer sizes for conv1 and pool1.
// These values must agree with the address widths
// in the package. The step constants in the
// generators are derived from them, but only
// square images and kernels are supported.
// ================================================
`ifndef CNN_ADDR_CFG_SVH
`define CNN_ADDR_CFG_SVH

// input image width in pixels
`define CNN_IMG_W 28

// kernel width and height
`define CNN_KSIZE 5

// convolution output width, IMG_W - KSIZE + 1
`define CNN_CONV_W 24

// pooling output width, CONV_W / 2
`define CNN_POOL_W 12

// parallel image read lanes
`define CNN_LANES 4
`define CNN_LANE_ROWS 6
`define CNN_LANE_WINDOWS 144

`endif
